/* verilog/flag_pkg.sv */
package flag_pkg;

	// Data path width of the execution unit
	localparam int WORD_W = 16;

	// Shift count width, up to 15 steps
	localparam int CNT_W = 4;

	// Number of user bits above the condition flags
	localparam int USER_W = 7;

	// Operand and result word
	typedef logic [WORD_W-1:0] flag_word_t;

	// Remaining shift steps
	typedef logic [CNT_W-1:0] shift_cnt_t;

	// Operations started by the strobe
	typedef enum logic [2:0] {
		OP_LOAD = 3'd0,
		OP_ADD  = 3'd1,
		OP_ADC  = 3'd2,
		OP_SUB  = 3'd3,
		OP_CMP  = 3'd4,
		OP_SHL  = 3'd5
	} op_t;

	// Status word split into flags, first member is the top bit
	typedef struct packed {
		// Bits 15..9, plain storage from the bus
		logic [USER_W-1:0] user;
		// Bit 8, any one shifted out since the shift began
		logic x;
		// Bit 7, last bit shifted out
		logic y;
		// Bit 6, greater
		logic g;
		// Bit 5, equal
		logic e;
		// Bit 4, less
		logic l;
		// Bit 3, carry or no borrow
		logic c;
		// Bit 2, sticky overflow
		logic v;
		// Bit 1, minus
		logic m;
		// Bit 0, zero
		logic z;
	} status_fields_t;

	// Same 16 bits seen as a bus word or as flags
	typedef union packed {
		flag_word_t     raw;
		status_fields_t fields;
	} status_u;

endpackage

/* verilog/flag_if.sv */
`timescale 1ns/10ps

interface flag_if;

	// Update strobes, one cycle wide, from the FSM
	logic upd_zmc;
	logic upd_v;
	logic upd_leg;
	logic upd_shift;
	logic clr_x;
	logic load_w;

	// Condition values from the ALU
	logic zero;
	logic sign;
	logic carry;
	logic ovf;
	logic lt;
	logic eq;
	logic gt;
	// Bit leaving the top of the word on a shift
	logic out_bit;

	// Control side
	modport ctl (output upd_zmc, upd_v, upd_leg, upd_shift, clr_x, load_w);

	// ALU side
	modport cond (output zero, sign, carry, ovf, lt, eq, gt, out_bit);

	// Status register side, sees everything
	modport regs (
		input upd_zmc, upd_v, upd_leg, upd_shift, clr_x, load_w,
		input zero, sign, carry, ovf, lt, eq, gt, out_bit
	);

endinterface

/* verilog/alu16.sv */
`timescale 1ns/10ps

module alu16 import flag_pkg::*; (
	input  op_t        op,
	input  flag_word_t a,
	input  flag_word_t b,
	input  logic       carry_in,
	output flag_word_t result,
	flag_if.cond       cond
);

	// Second adder input, inverted for subtract
	flag_word_t b_eff;
	// Carry into bit 0
	logic cin;
	// Sum with carry out on top
	logic [WORD_W:0] sum;
	// Word shifted left by one
	flag_word_t shl;

	// SUB is a + ~b + 1 so carry out means no borrow
	assign b_eff = (op == OP_SUB) ? ~b : b;

	// ADC takes the stored C flag
	always_comb begin
		case (op)
			OP_SUB:  cin = 1'b1;
			OP_ADC:  cin = carry_in;
			default: cin = 1'b0;
		endcase
	end

	assign sum = {1'b0, a} + {1'b0, b_eff} + {{WORD_W{1'b0}}, cin};

	// Zero fills from the right
	assign shl = {a[WORD_W-2:0], 1'b0};

	// Result select
	always_comb begin
		case (op)
			OP_ADD, OP_ADC, OP_SUB: result = sum[WORD_W-1:0];
			OP_SHL:                 result = shl;
			// LOAD and CMP pass a through
			default:                result = a;
		endcase
	end

	// Z and M follow the selected result
	assign cond.zero = (result == '0);
	assign cond.sign = result[WORD_W-1];

	// Carry out of the adder
	assign cond.carry = sum[WORD_W];

	// Operands of one sign giving a result of the other sign
	// b_eff covers both add and subtract
	assign cond.ovf = (a[WORD_W-1] == b_eff[WORD_W-1]) &&
		(sum[WORD_W-1] != a[WORD_W-1]);

	// Unsigned compare of the raw operands
	assign cond.lt = (a < b);
	assign cond.eq = (a == b);
	assign cond.gt = (a > b);

	// Old top bit leaves on a left shift
	assign cond.out_bit = a[WORD_W-1];

endmodule

/* verilog/flag_reg.sv */
`timescale 1ns/10ps

module flag_reg import flag_pkg::*; (
	input  logic       lrp,
	input  logic       zer_,
	// Bus word for LOAD
	input  flag_word_t w,
	flag_if.regs       regs,
	output status_u    status
);

	// Register contents
	status_u st;

	// One clock, one async clear, group enables instead of latches
	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			st.raw <= '0;
		end else if (regs.load_w) begin
			// Whole word including V and the user bits
			st.raw <= w;
		end else begin
			// Z, M and C after an arithmetic op
			if (regs.upd_zmc) begin
				st.fields.z <= regs.zero;
				st.fields.m <= regs.sign;
				st.fields.c <= regs.carry;
			end

			// V only ever sets here
			// cleared by a LOAD with bit 2 low
			if (regs.upd_v) begin
				st.fields.v <= st.fields.v | regs.ovf;
			end

			// L, E and G from the compare
			if (regs.upd_leg) begin
				st.fields.l <= regs.lt;
				st.fields.e <= regs.eq;
				st.fields.g <= regs.gt;
			end

			// X restarts at the head of a shift
			if (regs.clr_x) begin
				st.fields.x <= 1'b0;
			end else if (regs.upd_shift) begin
				// Y tracks the latest bit out
				st.fields.y <= regs.out_bit;
				// X accumulates ones
				st.fields.x <= st.fields.x | regs.out_bit;
			end
		end
	end

	// Also feeds C back to the ALU through the top
	assign status = st;

endmodule

/* verilog/step_timer.sv */
`timescale 1ns/10ps

module step_timer import flag_pkg::*; (
	input  logic       lrp,
	input  logic       zer_,
	// Take a new count
	input  logic       load,
	input  shift_cnt_t count,
	// One shift step done
	input  logic       step,
	// No steps left
	output logic       expired
);

	// Steps still to do
	shift_cnt_t remain;

	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			remain <= '0;
		end else if (load) begin
			remain <= count;
		end else if (step && (remain != '0)) begin
			// Stops at zero, never wraps
			remain <= remain - 1'b1;
		end
	end

	// Straight from the counter, seen in the same cycle
	assign expired = (remain == '0);

endmodule

/* verilog/exec_fsm.sv */
`timescale 1ns/10ps

module exec_fsm import flag_pkg::*; (
	input  logic lrp,
	input  logic zer_,
	input  logic op_strobe,
	// Latched op from the operand register
	input  op_t  op,
	output logic busy,
	output logic done,
	flag_if.ctl  ctl,
	// Shift step timer control
	output logic step_load,
	input  logic step_expired,
	// Result register controls
	output logic res_load,
	output logic shift_step
);

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		SHIFT,
		FINISH
	} state_t;

	state_t state;
	state_t state_nxt;
	// Next value of done
	logic   done_nxt;

	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			state <= IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_nxt;
			done  <= done_nxt;
		end
	end

	always_comb begin
		state_nxt     = state;
		done_nxt      = 1'b0;
		step_load     = 1'b0;
		res_load      = 1'b0;
		shift_step    = 1'b0;
		ctl.upd_zmc   = 1'b0;
		ctl.upd_v     = 1'b0;
		ctl.upd_leg   = 1'b0;
		ctl.upd_shift = 1'b0;
		ctl.clr_x     = 1'b0;
		ctl.load_w    = 1'b0;

		case (state)
			// Strobe only taken here, ignored while busy
			IDLE: begin
				if (op_strobe) begin
					state_nxt = EXEC;
				end
			end

			// Operands are latched, register the ALU result
			EXEC: begin
				res_load = 1'b1;
				if (op == OP_SHL) begin
					// Arm the timer and drop X for the new shift
					step_load = 1'b1;
					ctl.clr_x = 1'b1;
					state_nxt = SHIFT;
				end else begin
					state_nxt = FINISH;
				end
			end

			// One bit per cycle, last cycle only signals done
			SHIFT: begin
				if (step_expired) begin
					done_nxt  = 1'b1;
					state_nxt = IDLE;
				end else begin
					shift_step    = 1'b1;
					ctl.upd_shift = 1'b1;
				end
			end

			// Flag write, conditions still valid from the held operands
			FINISH: begin
				case (op)
					OP_LOAD: ctl.load_w = 1'b1;
					OP_ADD, OP_ADC, OP_SUB: begin
						ctl.upd_zmc = 1'b1;
						ctl.upd_v   = 1'b1;
					end
					OP_CMP:  ctl.upd_leg = 1'b1;
					default: ;
				endcase
				done_nxt  = 1'b1;
				state_nxt = IDLE;
			end

			default: state_nxt = IDLE;
		endcase
	end

	// Low again in the done cycle
	assign busy = (state != IDLE);

endmodule

/* verilog/flag_unit_top.sv */
`timescale 1ns/10ps

module flag_unit_top import flag_pkg::*; (
	input  logic        lrp,
	input  logic        zer_,
	input  logic        op_strobe,
	input  op_t         op,
	input  flag_word_t  opa,
	input  flag_word_t  opb,
	input  shift_cnt_t  count,
	output logic        busy,
	output logic        done,
	output logic [15:0] status,
	output flag_word_t  result
);

	// Held operation and operands
	op_t        op_q;
	flag_word_t a_q;
	flag_word_t b_q;
	shift_cnt_t cnt_q;
	flag_word_t result_q;

	// Block to block wiring
	flag_word_t alu_result;
	status_u    st;
	logic       accept;
	logic       step_load;
	logic       step_expired;
	logic       res_load;
	logic       shift_step;

	// One strobe and condition bundle
	flag_if fif ();

	// Strobe counts only when idle
	assign accept = op_strobe && !busy;

	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			op_q     <= OP_LOAD;
			result_q <= '0;
		end else begin
			if (accept) begin
				op_q <= op;
			end
			if (shift_step) begin
				result_q <= alu_result;
			end else if (res_load) begin
				// SHL starts from the unshifted word
				result_q <= (op_q == OP_SHL) ? a_q : alu_result;
			end
		end
	end

	// Operands, a doubles as the shift register
	always_ff @(posedge lrp) begin
		if (accept) begin
			a_q   <= opa;
			b_q   <= opb;
			cnt_q <= count;
		end else if (shift_step) begin
			a_q <= alu_result;
		end
	end

	exec_fsm u_fsm (
		.lrp          (lrp),
		.zer_         (zer_),
		.op_strobe    (op_strobe),
		.op           (op_q),
		.busy         (busy),
		.done         (done),
		.ctl          (fif.ctl),
		.step_load    (step_load),
		.step_expired (step_expired),
		.res_load     (res_load),
		.shift_step   (shift_step)
	);

	step_timer u_timer (
		.lrp     (lrp),
		.zer_    (zer_),
		.load    (step_load),
		.count   (cnt_q),
		.step    (shift_step),
		.expired (step_expired)
	);

	// C flag closes the ADC loop
	alu16 u_alu (
		.op       (op_q),
		.a        (a_q),
		.b        (b_q),
		.carry_in (st.fields.c),
		.result   (alu_result),
		.cond     (fif.cond)
	);

	// opa is the bus word for LOAD
	flag_reg u_reg (
		.lrp    (lrp),
		.zer_   (zer_),
		.w      (a_q),
		.regs   (fif.regs),
		.status (st)
	);

	assign status = st.raw;
	assign result = result_q;

endmodule

/* verif/flag_unit_tb.sv */
`timescale 1ns/10ps

module flag_unit_tb import flag_pkg::*; ();

	// Table size, fixed rows first, then random ones
	localparam int FIXED_ROWS = 21;
	localparam int RAND_ROWS = 12;
	localparam int NUM_ROWS = FIXED_ROWS + RAND_ROWS;
	localparam int RESET_CYCLES = 8;
	// Longest op is SHL by 15, done 18 cycles after the strobe edge
	localparam int DONE_WAIT = 19;
	localparam int CYCLE_LIMIT = NUM_ROWS * 20 + RESET_CYCLES;
	localparam logic [31:0] SEED = 32'had5a92c9;

	// One test, inputs plus predicted outputs
	typedef struct {
		string      name;
		op_t        op;
		flag_word_t opa;
		flag_word_t opb;
		shift_cnt_t count;
		// Second strobe while busy, must be dropped
		logic       dup;
		flag_word_t exp_result;
		status_u    exp_status;
	} row_t;

	logic       lrp;
	logic       zer_;
	logic       op_strobe;
	op_t        op;
	flag_word_t opa;
	flag_word_t opb;
	shift_cnt_t count;
	logic       busy;
	logic       done;
	status_u    status;
	flag_word_t result;

	row_t    tbl [NUM_ROWS];
	int      row_fill = 0;
	// Status as the reference model sees it after each row
	status_u model_st;
	int      mismatch_cnt = 0;
	int      missing_cnt = 0;
	int      cycles = 0;

	flag_unit_top DUT (
		.lrp       (lrp),
		.zer_      (zer_),
		.op_strobe (op_strobe),
		.op        (op),
		.opa       (opa),
		.opb       (opb),
		.count     (count),
		.busy      (busy),
		.done      (done),
		.status    (status),
		.result    (result)
	);

	always #5 lrp = ~lrp;

	// Watchdog over the whole run
	always @(posedge lrp) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic check_word(input string name, input flag_word_t exp, input flag_word_t act);
		if (exp !== act) begin
			mismatch_cnt++;
			$display("Mismatch %s result: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input status_u exp, input status_u act);
		if (exp.raw !== act.raw) begin
			mismatch_cnt++;
			$display("Mismatch %s status: expected %h actual %h", name, exp.raw, act.raw);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			mismatch_cnt++;
			$display("Mismatch %s: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic add_row(input string name, input op_t o, input flag_word_t a,
		input flag_word_t b, input shift_cnt_t n, input logic dup);
		tbl[row_fill].name = name;
		tbl[row_fill].op = o;
		tbl[row_fill].opa = a;
		tbl[row_fill].opb = b;
		tbl[row_fill].count = n;
		tbl[row_fill].dup = dup;
		row_fill++;
	endtask

	// Reference model, one row at a time, carries the status forward
	task automatic predict_row(input int i);
		logic [16:0] sum;
		flag_word_t  a;
		flag_word_t  b;
		flag_word_t  res;
		a = tbl[i].opa;
		b = tbl[i].opb;
		res = a;
		case (tbl[i].op)
			OP_LOAD: model_st.raw = a;
			OP_ADD, OP_ADC, OP_SUB: begin
				if (tbl[i].op == OP_SUB) begin
					res = a - b;
					// Carry set means no borrow
					model_st.fields.c = (a >= b);
					model_st.fields.v |= (a[15] != b[15]) && (res[15] != a[15]);
				end else begin
					sum = {1'b0, a} + {1'b0, b};
					if (tbl[i].op == OP_ADC) begin
						sum = sum + {16'h0000, model_st.fields.c};
					end
					res = sum[15:0];
					model_st.fields.c = sum[16];
					model_st.fields.v |= (a[15] == b[15]) && (res[15] != a[15]);
				end
				model_st.fields.z = (res == 16'h0000);
				model_st.fields.m = res[15];
			end
			// Unsigned compare only
			OP_CMP: begin
				model_st.fields.l = (a < b);
				model_st.fields.e = (a == b);
				model_st.fields.g = (a > b);
			end
			OP_SHL: begin
				model_st.fields.x = 1'b0;
				for (int k = 0; k < int'(tbl[i].count); k++) begin
					model_st.fields.y = res[15];
					model_st.fields.x |= res[15];
					res = res << 1;
				end
			end
			default: ;
		endcase
		tbl[i].exp_result = res;
		tbl[i].exp_status = model_st;
	endtask

	// Drive one row, optional extra strobe while busy, then wait for done
	task automatic apply_row(input int i);
		int waited;
		waited = 0;
		@(posedge lrp);
		op_strobe <= 1'b1;
		op <= tbl[i].op;
		opa <= tbl[i].opa;
		opb <= tbl[i].opb;
		count <= tbl[i].count;
		@(posedge lrp);
		op_strobe <= 1'b0;
		// Sample away from the active edge
		@(negedge lrp);
		// Strobe was taken on the last edge
		check_bit({tbl[i].name, " busy"}, 1'b1, busy);
		if (tbl[i].dup) begin
			@(posedge lrp);
			op_strobe <= 1'b1;
			op <= OP_LOAD;
			opa <= ~tbl[i].opa;
			opb <= ~tbl[i].opb;
			count <= 4'hf;
			@(posedge lrp);
			op_strobe <= 1'b0;
			@(negedge lrp);
		end
		while (!done && waited < DONE_WAIT) begin
			@(negedge lrp);
			waited++;
		end
		if (!done) begin
			missing_cnt++;
			$display("Test %s: done did not arrive within %0d cycles", tbl[i].name, DONE_WAIT);
		end else begin
			check_word(tbl[i].name, tbl[i].exp_result, result);
			check_status(tbl[i].name, tbl[i].exp_status, status);
		end
	endtask

	initial begin
		lrp = 1'b0;
		zer_ = 1'b0;
		op_strobe = 1'b0;
		op = OP_LOAD;
		opa = '0;
		opb = '0;
		count = '0;
		void'($urandom(SEED));

		// Load path and the full word
		add_row("load_all", OP_LOAD, 16'ha5c3, 16'h0000, 4'd0, 1'b0);
		add_row("load_clr", OP_LOAD, 16'h0000, 16'h0000, 4'd0, 1'b0);
		// Arithmetic flags, ADC picks up C from the row before
		add_row("add_zero", OP_ADD, 16'h0000, 16'h0000, 4'd0, 1'b0);
		add_row("add_carry", OP_ADD, 16'hffff, 16'h0001, 4'd0, 1'b0);
		add_row("adc_carry", OP_ADC, 16'h0001, 16'h0001, 4'd0, 1'b0);
		add_row("adc_nocarry", OP_ADC, 16'h0001, 16'h0001, 4'd0, 1'b0);
		add_row("sub_borrow", OP_SUB, 16'h0003, 16'h0005, 4'd0, 1'b0);
		add_row("sub_equal", OP_SUB, 16'h1234, 16'h1234, 4'd0, 1'b0);
		// V stays set until a LOAD
		add_row("add_ovf", OP_ADD, 16'h7fff, 16'h0001, 4'd0, 1'b0);
		add_row("add_v_sticky", OP_ADD, 16'h0002, 16'h0003, 4'd0, 1'b0);
		add_row("cmp_lt", OP_CMP, 16'h0001, 16'h8000, 4'd0, 1'b0);
		add_row("cmp_eq", OP_CMP, 16'h4321, 16'h4321, 4'd0, 1'b0);
		add_row("cmp_gt", OP_CMP, 16'hffff, 16'h0001, 4'd0, 1'b0);
		add_row("load_v_clr", OP_LOAD, 16'h7e00, 16'h0000, 4'd0, 1'b0);
		add_row("cmp_keep", OP_CMP, 16'h0010, 16'h0020, 4'd0, 1'b0);
		// Shifts, including count 0 and the longest one
		add_row("shl_4", OP_SHL, 16'hf00f, 16'h0000, 4'd4, 1'b0);
		add_row("shl_0", OP_SHL, 16'h1234, 16'h0000, 4'd0, 1'b0);
		add_row("shl_zero_out", OP_SHL, 16'h0fff, 16'h0000, 4'd3, 1'b0);
		add_row("shl_15", OP_SHL, 16'h0003, 16'h0000, 4'd15, 1'b0);
		// Strobes during busy
		add_row("busy_ignore", OP_ADD, 16'h0100, 16'h0200, 4'd0, 1'b1);
		add_row("busy_ignore_shl", OP_SHL, 16'hc001, 16'h0000, 4'd2, 1'b1);
		for (int r = 0; r < RAND_ROWS; r++) begin
			add_row("rand", op_t'($urandom_range(5, 0)), flag_word_t'($urandom),
				flag_word_t'($urandom), shift_cnt_t'($urandom), 1'b0);
		end

		model_st = '0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			predict_row(i);
		end

		repeat (RESET_CYCLES) @(posedge lrp);
		zer_ <= 1'b1;
		@(negedge lrp);
		check_word("reset", '0, result);
		check_status("reset", '0, status);
		check_bit("reset busy", 1'b0, busy);
		check_bit("reset done", 1'b0, done);

		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(i);
		end
		repeat (2) @(posedge lrp);

		$display("Errors: %0d mismatches, %0d missing done", mismatch_cnt, missing_cnt);
		if (mismatch_cnt == 0 && missing_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* flag_unit.f */
verilog/flag_pkg.sv
verilog/flag_if.sv
verilog/alu16.sv
verilog/flag_reg.sv
verilog/step_timer.sv
verilog/exec_fsm.sv
verilog/flag_unit_top.sv
verif/flag_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the flag_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module flag_unit_tb -f flag_unit.f \
	&& ./obj_dir/Vflag_unit_tb > sim.log 2>&1 \
	|| { echo "Build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
